/* common/holo_pkg.sv */
package holo_pkg;

  // one uart or spi byte
  typedef logic [7:0] byte_t;

  // bits in one frame on the display config port
  localparam int SPI_FRAME_BITS = 16;

  //////////////////////////////////////////////////////////////////////
  // top level defaults
  //////////////////////////////////////////////////////////////////////

  // 62.5 MHz over 62 is roughly 1 Mbaud
  localparam int DEF_CLKS_PER_BIT    = 62;
  // fpga_clk cycles per sclk half period
  localparam int DEF_SPI_HALF_PERIOD = 2;
  // return bytes waiting for the uart
  localparam int DEF_FIFO_DEPTH      = 4;

  // address leaves first so it sits in the upper byte
  typedef struct packed {
    byte_t addr;
    byte_t data;
  } spi_fields_t;

  // same 16 bits seen two ways
  // assembler fills the fields
  // spi master shifts raw out msb first
  typedef union packed {
    spi_fields_t               fields;
    logic [SPI_FRAME_BITS-1:0] raw;
  } spi_frame_u;

endpackage

/* source/frame_assembler.sv */
`timescale 1ns/1ps

module frame_assembler (
  input  logic                 fpga_clk,
  input  logic                 reset_all_cmd_w,
  input  logic                 rx_valid_i,
  input  holo_pkg::byte_t      rx_byte_i,
  output logic                 frame_req_o,
  output holo_pkg::spi_frame_u frame_o,
  input  logic                 frame_ack_i
);

  import holo_pkg::*;

  // high once the address of a pair has been taken
  logic  odd_q;
  byte_t addr_q;
  logic  addr_byte;
  logic  data_byte;

  assign addr_byte = rx_valid_i && !odd_q;
  assign data_byte = rx_valid_i && odd_q;

  //////////////////////////////////////////////////////////////////////
  // pairing and request handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // first byte after reset is always an address
      odd_q       <= 1'b0;
      frame_req_o <= 1'b0;
    end else begin
      if (rx_valid_i) begin
        odd_q <= ~odd_q;
      end
      // second byte completes the frame
      if (data_byte) begin
        frame_req_o <= 1'b1;
      end else if (frame_req_o && frame_ack_i) begin
        // master finished so release the request
        frame_req_o <= 1'b0;
      end
    end
  end

  // address parked until its data byte shows up
  // frame only changes when a full pair is in
  always_ff @(posedge fpga_clk) begin
    if (addr_byte) begin
      addr_q <= rx_byte_i;
    end
    if (data_byte) begin
      frame_o.fields.addr <= addr_q;
      frame_o.fields.data <= rx_byte_i;
    end
  end

endmodule

/* source/holo_bridge_top.sv */
`timescale 1ns/1ps

module holo_bridge_top #(
  parameter int clks_per_bit    = holo_pkg::DEF_CLKS_PER_BIT,
  parameter int spi_half_period = holo_pkg::DEF_SPI_HALF_PERIOD,
  parameter int fifo_depth      = holo_pkg::DEF_FIFO_DEPTH
) (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_cs_n_o,
  output logic spi_sclk_o,
  output logic spi_mosi_o,
  input  logic spi_miso_i
);

  import holo_pkg::*;

  // uart rx to assembler
  logic       rx_valid;
  byte_t      rx_byte;
  // assembler to spi master
  logic       frame_req;
  spi_frame_u frame;
  logic       frame_ack;
  byte_t      resp_byte;
  // fifo to uart tx
  logic       tx_req;
  byte_t      tx_byte;
  logic       tx_ack;

  //////////////////////////////////////////////////////////////////////
  // pc to display
  //////////////////////////////////////////////////////////////////////

  uart_rx #(.clks_per_bit(clks_per_bit)) uart_rx_inst (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  frame_assembler frame_assembler_inst (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .frame_req_o     (frame_req),
    .frame_o         (frame),
    .frame_ack_i     (frame_ack)
  );

  spi_master #(.spi_half_period(spi_half_period)) spi_master_inst (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .frame_req_i     (frame_req),
    .frame_i         (frame),
    .frame_ack_o     (frame_ack),
    .resp_byte_o     (resp_byte),
    .spi_cs_n_o      (spi_cs_n_o),
    .spi_sclk_o      (spi_sclk_o),
    .spi_mosi_o      (spi_mosi_o),
    .spi_miso_i      (spi_miso_i)
  );

  //////////////////////////////////////////////////////////////////////
  // display reply back to pc
  //////////////////////////////////////////////////////////////////////

  // fifo snoops the same ack the assembler sees
  resp_fifo #(.fifo_depth(fifo_depth)) resp_fifo_inst (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .frame_ack_i     (frame_ack),
    .resp_byte_i     (resp_byte),
    .tx_req_o        (tx_req),
    .tx_byte_o       (tx_byte),
    .tx_ack_i        (tx_ack)
  );

  uart_tx #(.clks_per_bit(clks_per_bit)) uart_tx_inst (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_req_i        (tx_req),
    .tx_byte_i       (tx_byte),
    .tx_ack_o        (tx_ack),
    .tx_serial_o     (uart_tx_o)
  );

endmodule

/* source/resp_fifo.sv */
`timescale 1ns/1ps

module resp_fifo #(
  parameter int fifo_depth = holo_pkg::DEF_FIFO_DEPTH
) (
  input  logic            fpga_clk,
  input  logic            reset_all_cmd_w,
  input  logic            frame_ack_i,
  input  holo_pkg::byte_t resp_byte_i,
  output logic            tx_req_o,
  output holo_pkg::byte_t tx_byte_o,
  input  logic            tx_ack_i
);

  import holo_pkg::*;

  localparam int PTR_W = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int CNT_W = $clog2(fifo_depth + 1);

  byte_t            mem_q [fifo_depth];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             ack_prev_q;
  logic             full;
  logic             empty;
  logic             wr_en;
  logic             rd_en;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full      = (count_q == CNT_W'(fifo_depth));
  assign empty     = (count_q == '0);
  // one entry per frame on the rising ack edge and dropped when full
  assign wr_en     = frame_ack_i && !ack_prev_q && !full;
  // uart done with the head byte
  assign rd_en     = tx_req_o && tx_ack_i;
  assign tx_byte_o = mem_q[rd_ptr_q];

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      ack_prev_q <= 1'b0;
      tx_req_o   <= 1'b0;
    end else begin
      ack_prev_q <= frame_ack_i;
      if (wr_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(wr_en) - CNT_W'(rd_en);
      // head byte offered once the last ack has cleared
      if (rd_en) begin
        tx_req_o <= 1'b0;
      end else if (!tx_req_o && !empty && !tx_ack_i) begin
        tx_req_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= resp_byte_i;
    end
  end

endmodule

/* spi/spi_master.sv */
`timescale 1ns/1ps

module spi_master #(
  parameter int spi_half_period = holo_pkg::DEF_SPI_HALF_PERIOD
) (
  input  logic                 fpga_clk,
  input  logic                 reset_all_cmd_w,
  input  logic                 frame_req_i,
  input  holo_pkg::spi_frame_u frame_i,
  output logic                 frame_ack_o,
  output holo_pkg::byte_t      resp_byte_o,
  output logic                 spi_cs_n_o,
  output logic                 spi_sclk_o,
  output logic                 spi_mosi_o,
  input  logic                 spi_miso_i
);

  import holo_pkg::*;

  localparam int DIV_W = $clog2(spi_half_period + 1);
  localparam int BIT_W = $clog2(SPI_FRAME_BITS);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_SHIFT = 2'd1;
  localparam logic [1:0] ST_ACK   = 2'd2;

  logic [1:0]                state_q;
  logic [DIV_W-1:0]          div_q;
  logic [BIT_W-1:0]          bit_q;
  logic [SPI_FRAME_BITS-1:0] shift_q;
  byte_t                     rx_q;
  logic                      start;
  logic                      half_done;
  logic                      sclk_rise;
  logic                      sclk_fall;

  assign start     = (state_q == ST_IDLE) && frame_req_i && !frame_ack_o;
  assign half_done = (state_q == ST_SHIFT) && (div_q == DIV_W'(spi_half_period - 1));
  // sclk about to toggle
  assign sclk_rise = half_done && !spi_sclk_o;
  assign sclk_fall = half_done && spi_sclk_o;

  //////////////////////////////////////////////////////////////////////
  // control fsm and sclk divider
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q     <= ST_IDLE;
      div_q       <= '0;
      bit_q       <= '0;
      frame_ack_o <= 1'b0;
      spi_cs_n_o  <= 1'b1;
      spi_sclk_o  <= 1'b0;
      spi_mosi_o  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            spi_cs_n_o <= 1'b0;
            // first bit must be settled before the first rising edge
            spi_mosi_o <= frame_i.raw[SPI_FRAME_BITS-1];
            div_q      <= '0;
            bit_q      <= '0;
            state_q    <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          div_q <= half_done ? '0 : div_q + 1'b1;
          if (half_done) begin
            spi_sclk_o <= ~spi_sclk_o;
          end
          // mode 0 so mosi changes on the falling edge
          if (sclk_fall) begin
            if (bit_q == BIT_W'(SPI_FRAME_BITS - 1)) begin
              state_q <= ST_ACK;
            end else begin
              bit_q      <= bit_q + 1'b1;
              spi_mosi_o <= shift_q[SPI_FRAME_BITS-2];
            end
          end
        end
        default: begin
          // cs and ack rise together one cycle after the last fall
          if (!frame_ack_o) begin
            spi_cs_n_o  <= 1'b1;
            spi_mosi_o  <= 1'b0;
            frame_ack_o <= 1'b1;
          end else if (!frame_req_i) begin
            frame_ack_o <= 1'b0;
            state_q     <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // shift out msb first and capture miso on the rising edge
  always_ff @(posedge fpga_clk) begin
    if (start) begin
      shift_q <= frame_i.raw;
    end else if (sclk_fall) begin
      shift_q <= {shift_q[SPI_FRAME_BITS-2:0], 1'b0};
    end
    if (sclk_rise) begin
      rx_q <= {rx_q[6:0], spi_miso_i};
    end
    // last eight bits in are the data half reply
    if (state_q == ST_ACK && !frame_ack_o) begin
      resp_byte_o <= rx_q;
    end
  end

endmodule

/* uart/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
  parameter int clks_per_bit = holo_pkg::DEF_CLKS_PER_BIT
) (
  input  logic            fpga_clk,
  input  logic            reset_all_cmd_w,
  input  logic            rx_serial_i,
  output logic            rx_valid_o,
  output holo_pkg::byte_t rx_byte_o
);

  import holo_pkg::*;

  localparam int CNT_W = $clog2(clks_per_bit + 1);
  // start bit is checked half a bit in
  localparam int HALF_BIT = (clks_per_bit - 1) / 2;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic             rx_meta_q;
  logic             rx_sync_q;
  logic [1:0]       state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_idx_q;
  byte_t            shift_q;
  logic             bit_done;

  // one full bit time elapsed
  assign bit_done  = (clk_cnt_q == CNT_W'(clks_per_bit - 1));
  assign rx_byte_o = shift_q;

  // two flop synchronizer, line idles high
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= ST_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      // single cycle strobe
      rx_valid_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          clk_cnt_q <= '0;
          if (!rx_sync_q) begin
            state_q <= ST_START;
          end
        end
        ST_START: begin
          if (clk_cnt_q == CNT_W'(HALF_BIT)) begin
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            // glitch shorter than half a bit goes back to idle
            state_q   <= rx_sync_q ? ST_IDLE : ST_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        ST_DATA: begin
          if (bit_done) begin
            clk_cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              state_q <= ST_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 3'd1;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          if (bit_done) begin
            state_q    <= ST_IDLE;
            // framing error drops the byte
            rx_valid_o <= rx_sync_q;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb arrives first so shift in from the top
  always_ff @(posedge fpga_clk) begin
    if (state_q == ST_DATA && bit_done) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

endmodule

/* uart/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = holo_pkg::DEF_CLKS_PER_BIT
) (
  input  logic            fpga_clk,
  input  logic            reset_all_cmd_w,
  input  logic            tx_req_i,
  input  holo_pkg::byte_t tx_byte_i,
  output logic            tx_ack_o,
  output logic            tx_serial_o
);

  import holo_pkg::*;

  localparam int CNT_W = $clog2(clks_per_bit + 1);

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_START = 3'd1;
  localparam logic [2:0] ST_DATA  = 3'd2;
  localparam logic [2:0] ST_STOP  = 3'd3;
  localparam logic [2:0] ST_ACK   = 3'd4;

  logic [2:0]       state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_idx_q;
  byte_t            shift_q;
  logic             bit_done;
  logic             start;

  assign bit_done = (clk_cnt_q == CNT_W'(clks_per_bit - 1));
  // new request only once the previous ack is gone
  assign start    = (state_q == ST_IDLE) && tx_req_i && !tx_ack_o;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q     <= ST_IDLE;
      clk_cnt_q   <= '0;
      bit_idx_q   <= '0;
      tx_ack_o    <= 1'b0;
      tx_serial_o <= 1'b1;
    end else begin
      // bit timer restarts on every state change below
      clk_cnt_q <= bit_done ? '0 : clk_cnt_q + 1'b1;
      case (state_q)
        ST_IDLE: begin
          clk_cnt_q <= '0;
          if (start) begin
            // start bit
            tx_serial_o <= 1'b0;
            state_q     <= ST_START;
          end
        end
        ST_START: begin
          if (bit_done) begin
            tx_serial_o <= shift_q[0];
            bit_idx_q   <= '0;
            state_q     <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (bit_done) begin
            if (bit_idx_q == 3'd7) begin
              // stop bit
              tx_serial_o <= 1'b1;
              state_q     <= ST_STOP;
            end else begin
              // shift_q moves down on this same edge
              tx_serial_o <= shift_q[1];
              bit_idx_q   <= bit_idx_q + 3'd1;
            end
          end
        end
        ST_STOP: begin
          if (bit_done) begin
            tx_ack_o <= 1'b1;
            state_q  <= ST_ACK;
          end
        end
        default: begin
          clk_cnt_q <= '0;
          // hold ack until the requester lets go
          if (!tx_req_i) begin
            tx_ack_o <= 1'b0;
            state_q  <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // byte latched at request and sent lsb first
  always_ff @(posedge fpga_clk) begin
    if (start) begin
      shift_q <= tx_byte_i;
    end else if (state_q == ST_DATA && bit_done) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

/* verification/bridge_input.txt */
// columns: address byte, data byte, miso reply in the data half (hex)
// the reply is what must come back on the uart
00 00 00
ff ff ff
bc 01 a5
12 bc 3c
bc bc bc
00 ff 5a
ff 00 c3
01 80 7e
a5 5a 81
3c c3 00
7f fe ff
80 01 bc
c0 de 42
ee 11 99

/* verification/holo_bridge_properties.sv */
`timescale 1ns/1ps

module holo_bridge_properties (
  input logic fpga_clk,
  input logic reset_all_cmd_w,
  input logic frame_req_i,
  input logic frame_ack_i,
  input logic rx_valid_i,
  input logic tx_req_i,
  input logic tx_ack_i,
  input logic spi_cs_n_i
);

  // count of failed assertions
  int violation_cnt = 0;

  //////////////////////////////////////////////////////////////////////
  // four phase handshakes
  //////////////////////////////////////////////////////////////////////

  // ack may outlive req by a cycle, but may only rise under it
  frame_ack_under_req: assert property (
    @(posedge fpga_clk) disable iff (reset_all_cmd_w)
    $rose(frame_ack_i) |-> frame_req_i
  ) else begin
    violation_cnt = violation_cnt + 1;
    $error("frame_ack rose while frame_req was low");
  end

  tx_ack_under_req: assert property (
    @(posedge fpga_clk) disable iff (reset_all_cmd_w)
    $rose(tx_ack_i) |-> tx_req_i
  ) else begin
    violation_cnt = violation_cnt + 1;
    $error("tx_ack rose while tx_req was low");
  end

  //////////////////////////////////////////////////////////////////////
  // spi bus and receive side
  //////////////////////////////////////////////////////////////////////

  // chip select only inside a request
  cs_inside_req: assert property (
    @(posedge fpga_clk) disable iff (reset_all_cmd_w)
    !spi_cs_n_i |-> frame_req_i
  ) else begin
    violation_cnt = violation_cnt + 1;
    $error("spi_cs_n low without frame_req");
  end

  // uart bytes are slower than a whole frame
  no_rx_while_busy: assert property (
    @(posedge fpga_clk) disable iff (reset_all_cmd_w)
    rx_valid_i |-> !frame_req_i
  ) else begin
    violation_cnt = violation_cnt + 1;
    $error("rx_valid arrived while frame_req was high");
  end

endmodule

bind holo_bridge_top holo_bridge_properties holo_bridge_properties_inst (
  .fpga_clk        (fpga_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .frame_req_i     (frame_req),
  .frame_ack_i     (frame_ack),
  .rx_valid_i      (rx_valid),
  .tx_req_i        (tx_req),
  .tx_ack_i        (tx_ack),
  .spi_cs_n_i      (spi_cs_n_o)
);

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 5
) (
  output logic fpga_clk_o,
  output logic por_reset_o
);

  // free running clock, low at time zero
  initial begin
    fpga_clk_o = 1'b0;
    forever #(period_ns / 2) fpga_clk_o = ~fpga_clk_o;
  end

  // power on reset, released on a falling edge
  initial begin
    por_reset_o = 1'b1;
    repeat (reset_cycles) @(posedge fpga_clk_o);
    @(negedge fpga_clk_o);
    por_reset_o = 1'b0;
  end

endmodule

/* verification/tb_holo_bridge.sv */
`timescale 1ns/1ps

module tb_holo_bridge;

  import holo_pkg::*;

  localparam int CLKS_PER_BIT    = 8;
  localparam int SPI_HALF_PERIOD = 2;
  localparam int MAX_LINES       = 32;

  logic        fpga_clk;
  logic        por_reset;
  logic        tb_reset = 1'b0;
  logic        reset_all_cmd_w;
  logic        uart_rx_i;
  logic        uart_tx_o;
  logic        spi_cs_n_o;
  logic        spi_sclk_o;
  logic        spi_mosi_o;
  logic        spi_miso_i = 1'b0;

  // three bytes per file row as addr, data and miso reply
  byte_t       stim_mem [3*MAX_LINES];
  spi_frame_u  exp_frames [MAX_LINES+2];
  byte_t       exp_resps [MAX_LINES+2];
  int          n_total = 0;
  int          frame_cnt = 0;
  int          echo_cnt = 0;
  int          cycle_cnt = 0;
  int          timeout_limit = 32'h7fff_ffff;
  int          seed = 90609;
  logic        idle_watch = 1'b0;
  // spi slave model state
  logic        in_frame = 1'b0;
  int          rise_cnt = 0;
  int          fall_cnt = 0;
  logic [15:0] mosi_word;
  logic [15:0] miso_word;

  assign reset_all_cmd_w = por_reset | tb_reset;

  tb_clock_gen #(.period_ns(8), .reset_cycles(5)) tb_clock_gen_inst (
    .fpga_clk_o  (fpga_clk),
    .por_reset_o (por_reset)
  );

  holo_bridge_top #(
    .clks_per_bit    (CLKS_PER_BIT),
    .spi_half_period (SPI_HALF_PERIOD),
    .fifo_depth      (DEF_FIFO_DEPTH)
  ) holo_bridge_top_inst (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .uart_tx_o       (uart_tx_o),
    .spi_cs_n_o      (spi_cs_n_o),
    .spi_sclk_o      (spi_sclk_o),
    .spi_mosi_o      (spi_mosi_o),
    .spi_miso_i      (spi_miso_i)
  );

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
      report_failure("single bit level mismatch");
    end
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
      report_failure("byte mismatch");
    end
  endtask

  task automatic check_frame(input string name, input spi_frame_u exp, input spi_frame_u act);
    if (act.raw !== exp.raw) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp.raw, act.raw);
      report_failure("spi frame mismatch");
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
      report_failure("count mismatch");
    end
  endtask

  // run limit from the number of transactions
  always @(posedge fpga_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > timeout_limit) begin
      report_failure("timeout, the echo bytes did not all come back in time");
    end
  end

  // bound handshake and bus assertions
  always @(negedge fpga_clk) begin
    if (holo_bridge_top_inst.holo_bridge_properties_inst.violation_cnt != 0) begin
      report_failure("a handshake or bus assertion failed");
    end
  end

  // outputs stay idle until the first pair is in
  always @(negedge fpga_clk) begin
    if (idle_watch && !reset_all_cmd_w) begin
      check_level("uart_tx_o", 1'b1, uart_tx_o);
      check_level("spi_cs_n_o", 1'b1, spi_cs_n_o);
      check_level("spi_sclk_o", 1'b0, spi_sclk_o);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // spi slave model
  //////////////////////////////////////////////////////////////////////

  always @(negedge spi_cs_n_o) begin
    if (!reset_all_cmd_w) begin
      if (frame_cnt >= n_total) begin
        report_failure("spi_cs_n_o fell for a frame that was never sent");
      end
      in_frame  = 1'b1;
      rise_cnt  = 0;
      fall_cnt  = 0;
      mosi_word = '0;
      // zeros during the address half
      miso_word = {8'h00, exp_resps[frame_cnt]};
    end
  end

  always @(posedge spi_sclk_o) begin
    if (in_frame) begin
      mosi_word = {mosi_word[14:0], spi_mosi_o};
      rise_cnt  = rise_cnt + 1;
    end
  end

  always @(negedge spi_sclk_o) begin
    if (in_frame) begin
      fall_cnt = fall_cnt + 1;
    end
  end

  // next miso bit set up well before the rising sclk
  always @(negedge fpga_clk) begin
    if (in_frame && fall_cnt < 16) begin
      spi_miso_i <= miso_word[15-fall_cnt];
    end else begin
      spi_miso_i <= 1'b0;
    end
  end

  always @(posedge spi_cs_n_o) begin
    spi_frame_u got;
    if (in_frame) begin
      in_frame = 1'b0;
      got.raw  = mosi_word;
      check_count("spi_sclk_o rising edges", 16, rise_cnt);
      check_frame("spi_mosi_o", exp_frames[frame_cnt], got);
      frame_cnt = frame_cnt + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // uart driver and monitor
  //////////////////////////////////////////////////////////////////////

  // called and returns on a falling edge
  task automatic drive_bit(input logic val);
    uart_rx_i = val;
    repeat (CLKS_PER_BIT) @(negedge fpga_clk);
  endtask

  task automatic send_byte(input byte_t b);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(1'b1);
    // two bit gap
    drive_bit(1'b1);
    drive_bit(1'b1);
  endtask

  task automatic send_pair(input int idx);
    send_byte(exp_frames[idx].fields.addr);
    // display may start moving once the data byte is out
    idle_watch = 1'b0;
    send_byte(exp_frames[idx].fields.data);
  endtask

  task automatic wait_for_echoes(input int target);
    while (echo_cnt < target) begin
      @(negedge fpga_clk);
    end
  endtask

  task automatic load_txn(input int idx, input byte_t a, input byte_t d, input byte_t r);
    exp_frames[idx].fields.addr = a;
    exp_frames[idx].fields.data = d;
    exp_resps[idx]              = r;
  endtask

  initial begin : uart_monitor
    byte_t rx_b;
    forever begin
      @(negedge fpga_clk);
      if (!reset_all_cmd_w && uart_tx_o === 1'b0) begin
        // middle of the start bit then bit centers
        repeat (CLKS_PER_BIT / 2) @(negedge fpga_clk);
        if (uart_tx_o !== 1'b0) begin
          report_failure("start bit on uart_tx_o was shorter than half a bit");
        end
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge fpga_clk);
          rx_b[i] = uart_tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge fpga_clk);
        if (uart_tx_o !== 1'b1) begin
          report_failure("stop bit on uart_tx_o was low");
        end
        if (echo_cnt >= n_total) begin
          report_failure("uart_tx_o echoed a byte that no frame produced");
        end
        check_byte("uart_tx_o", exp_resps[echo_cnt], rx_b);
        echo_cnt = echo_cnt + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main_flow
    int n_file;
    int rnd;
    uart_rx_i = 1'b1;
    n_file    = 0;
    $readmemh("verification/bridge_input.txt", stim_mem);
    while (n_file < MAX_LINES && !$isunknown(stim_mem[3*n_file])) begin
      load_txn(n_file, stim_mem[3*n_file], stim_mem[3*n_file+1], stim_mem[3*n_file+2]);
      n_file = n_file + 1;
    end
    if (n_file == 0) begin
      report_failure("no transactions found in verification/bridge_input.txt");
    end
    // one random row and the last file row again for the reset test
    rnd = $random(seed);
    load_txn(n_file, rnd[7:0], rnd[15:8], rnd[23:16]);
    load_txn(n_file + 1, stim_mem[3*n_file-3], stim_mem[3*n_file-2], stim_mem[3*n_file-1]);
    n_total       = n_file + 2;
    timeout_limit = 2 * n_total * 40 * CLKS_PER_BIT;

    @(negedge fpga_clk);
    while (reset_all_cmd_w !== 1'b0) begin
      @(negedge fpga_clk);
    end
    @(negedge fpga_clk);
    idle_watch = 1'b1;

    // pairs back to back with echoes checked as they come
    for (int i = 0; i <= n_file; i++) begin
      send_pair(i);
    end
    wait_for_echoes(n_file + 1);

    // stray address byte and then a second reset
    send_byte(stim_mem[3*n_file-2]);
    tb_reset = 1'b1;
    repeat (5) @(negedge fpga_clk);
    tb_reset   = 1'b0;
    idle_watch = 1'b1;
    @(negedge fpga_clk);
    send_pair(n_file + 1);
    wait_for_echoes(n_total);

    // quiet tail catches extra frames or echoes
    repeat (20 * CLKS_PER_BIT) @(negedge fpga_clk);
    check_count("spi frames", n_total, frame_cnt);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* verilog.f */
common/holo_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
spi/spi_master.sv
source/frame_assembler.sv
source/resp_fifo.sv
source/holo_bridge_top.sv
verification/tb_clock_gen.sv
verification/holo_bridge_properties.sv
verification/tb_holo_bridge.sv
